//--- wb_arbiter_pkg.sv
// Write-back arbiter shared definitions
// Widths, unit count, result and write-port structs, turn state

package wb_arbiter_pkg;

    localparam int NUM_UNITS      = 8;
    localparam int UNIT_IDX_WIDTH = 3;
    localparam int TAG_WIDTH      = 5;
    localparam int GPR_ADDR_WIDTH = 5;
    localparam int SPR_ADDR_WIDTH = 10;
    localparam int DATA_WIDTH     = 32;

    // XER lives at SPR number 1
    localparam logic [0:SPR_ADDR_WIDTH-1] XER_SPR_ADDR = 10'd1;

    // Condition and exception side effects of one result
    typedef struct packed {
        logic                    xer_valid;
        logic [0:DATA_WIDTH-1]   xer;
        logic                    cr0_valid;
        logic                    so;
    } cond_exc_t;

    typedef struct packed {
        logic [0:TAG_WIDTH-1]      tag;
        logic [0:GPR_ADDR_WIDTH-1] reg_addr;
        logic [0:DATA_WIDTH-1]     data;
        cond_exc_t                 cond;
    } gpr_result_t;

    typedef struct packed {
        logic                      valid;
        logic [0:TAG_WIDTH-1]      tag;
        logic [0:GPR_ADDR_WIDTH-1] reg_addr;
        logic [0:DATA_WIDTH-1]     data;
    } gpr_write_t;

    typedef struct packed {
        logic                      valid;
        logic [0:TAG_WIDTH-1]      tag;
        logic [0:SPR_ADDR_WIDTH-1] spr_addr;
        logic [0:DATA_WIDTH-1]     data;
    } spr_write_t;

    // Field bits are lt, gt, eq, so
    typedef struct packed {
        logic                 valid;
        logic [0:TAG_WIDTH-1] tag;
        logic [0:3]           field;
    } cr0_write_t;

    // Who gets the SPR port on the next conflict
    typedef enum logic {
        turn_gpr,
        turn_spr
    } turn_state_t;

    typedef struct packed {
        logic                      gpr_en;
        logic [0:UNIT_IDX_WIDTH-1] unit_idx;
        logic                      spr_en;
    } grant_t;

endpackage

//--- rr_pointer.sv
// Round-robin start pointer for the unit search
// Moves one past the unit that was just granted

`timescale 1ns/1ps

module rr_pointer import wb_arbiter_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  grant_t                    grant,
    output logic [0:UNIT_IDX_WIDTH-1] ptr
);

    localparam logic [0:UNIT_IDX_WIDTH-1] LAST_IDX = UNIT_IDX_WIDTH'(NUM_UNITS - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= '0;
        end else if (grant.gpr_en) begin
            // Wrap explicitly so a unit count below 2**width still works
            if (grant.unit_idx == LAST_IDX) begin
                ptr <= '0;
            end else begin
                ptr <= grant.unit_idx + 1'b1;
            end
        end
    end

endmodule

//--- unit_search.sv
// Rotating priority search over the GPR result units
// Finds the first valid unit and the first valid unit without an XER update

`timescale 1ns/1ps

module unit_search import wb_arbiter_pkg::*; (
    input  logic [0:UNIT_IDX_WIDTH-1] ptr,
    input  logic [0:NUM_UNITS-1]      unit_valid,
    input  gpr_result_t               unit_result [0:NUM_UNITS-1],
    output logic [0:UNIT_IDX_WIDTH-1] first_idx,
    output logic                      first_found,
    output logic [0:UNIT_IDX_WIDTH-1] noxer_idx,
    output logic                      noxer_found
);

    logic [0:NUM_UNITS-1] noxer_req;

    // First set request at or after start, wrapping around
    function automatic logic find_first(
        input  logic [0:NUM_UNITS-1]      req,
        input  logic [0:UNIT_IDX_WIDTH-1] start,
        output logic [0:UNIT_IDX_WIDTH-1] idx
    );
        logic [0:UNIT_IDX_WIDTH-1] cand;
        logic                      found;
        found = 1'b0;
        idx   = start;
        for (int i = 0; i < NUM_UNITS; i++) begin
            cand = UNIT_IDX_WIDTH'((int'(start) + i) % NUM_UNITS);
            if (req[cand] && !found) begin
                idx   = cand;
                found = 1'b1;
            end
        end
        return found;
    endfunction

    // Units that could share a cycle with the SPR source
    always_comb begin
        for (int i = 0; i < NUM_UNITS; i++) begin
            noxer_req[i] = unit_valid[i] & ~unit_result[i].cond.xer_valid;
        end
    end

    always_comb begin
        first_found = find_first(unit_valid, ptr, first_idx);
        noxer_found = find_first(noxer_req, ptr, noxer_idx);
    end

endmodule

//--- spr_turn_fsm.sv
// SPR port turn FSM
// Alternates the SPR write port between the GPR units and the SPR source
// and decodes the grant into the ready signals

`timescale 1ns/1ps

module spr_turn_fsm import wb_arbiter_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      spr_valid,
    input  logic [0:UNIT_IDX_WIDTH-1] first_idx,
    input  logic                      first_found,
    input  logic [0:UNIT_IDX_WIDTH-1] noxer_idx,
    input  logic                      noxer_found,
    output grant_t                    grant,
    output logic [0:NUM_UNITS-1]      unit_ready,
    output logic                      spr_ready
);

    turn_state_t state;
    turn_state_t state_nxt;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= turn_gpr;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        grant.gpr_en   = 1'b0;
        grant.unit_idx = first_idx;
        grant.spr_en   = 1'b0;
        state_nxt      = state;

        if (!spr_valid) begin
            // No competition for the SPR port
            grant.gpr_en = first_found;
        end else if (state == turn_spr) begin
            // SPR source is owed the port, pair it with a unit if one fits
            grant.spr_en   = 1'b1;
            grant.gpr_en   = noxer_found;
            grant.unit_idx = noxer_idx;
            state_nxt      = turn_gpr;
        end else begin
            if (noxer_found) begin
                grant.spr_en   = 1'b1;
                grant.gpr_en   = 1'b1;
                grant.unit_idx = noxer_idx;
            end else if (first_found) begin
                // Only XER writers are waiting, the unit goes first
                grant.gpr_en = 1'b1;
            end else begin
                grant.spr_en = 1'b1;
            end
            state_nxt = turn_spr;
        end
    end

    // One-hot ready back to the units
    always_comb begin
        unit_ready = '0;
        if (grant.gpr_en) begin
            unit_ready[grant.unit_idx] = 1'b1;
        end
    end

    assign spr_ready = grant.spr_en;

endmodule

//--- wb_output_stage.sv
// Write-back output stage
// Muxes the granted unit, derives CR0, merges the SPR source onto the
// SPR port and registers the GPR, SPR and CR0 write ports

`timescale 1ns/1ps

module wb_output_stage import wb_arbiter_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  grant_t      grant,
    input  gpr_result_t unit_result [0:NUM_UNITS-1],
    input  spr_write_t  spr_in,
    output gpr_write_t  gpr_wr,
    output spr_write_t  spr_wr,
    output cr0_write_t  cr0_wr
);

    gpr_result_t sel;
    gpr_write_t  gpr_nxt;
    spr_write_t  spr_nxt;
    cr0_write_t  cr0_nxt;

    // CR0 is lt, gt, eq from a signed compare with zero, then so
    function automatic logic [0:3] cr0_field(
        input logic [0:DATA_WIDTH-1] data,
        input logic                  so
    );
        if ($signed(data) < 0) begin
            return {3'b100, so};
        end else if ($signed(data) > 0) begin
            return {3'b010, so};
        end else begin
            return {3'b001, so};
        end
    endfunction

    assign sel = unit_result[grant.unit_idx];

    always_comb begin
        gpr_nxt.valid    = grant.gpr_en;
        gpr_nxt.tag      = sel.tag;
        gpr_nxt.reg_addr = sel.reg_addr;
        gpr_nxt.data     = sel.data;

        cr0_nxt.valid = grant.gpr_en & sel.cond.cr0_valid;
        cr0_nxt.tag   = sel.tag;
        cr0_nxt.field = cr0_field(sel.data, sel.cond.so);

        // The FSM never grants the SPR source together with an XER writer
        if (grant.spr_en) begin
            spr_nxt       = spr_in;
            spr_nxt.valid = 1'b1;
        end else begin
            spr_nxt.valid    = grant.gpr_en & sel.cond.xer_valid;
            spr_nxt.tag      = sel.tag;
            spr_nxt.spr_addr = XER_SPR_ADDR;
            spr_nxt.data     = sel.cond.xer;
        end
    end

    always_ff @(posedge clk) begin
        gpr_wr <= gpr_nxt;
        spr_wr <= spr_nxt;
        cr0_wr <= cr0_nxt;
        if (rst) begin
            gpr_wr.valid <= 1'b0;
            spr_wr.valid <= 1'b0;
            cr0_wr.valid <= 1'b0;
        end
    end

endmodule

//--- write_back_arbiter.sv
// Write-back arbiter top level
// One GPR result per cycle in round-robin order, with XER and CR0 side
// effects, sharing the SPR write port with a single SPR result source

`timescale 1ns/1ps

module write_back_arbiter import wb_arbiter_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,

    // Execution unit results
    input  logic [0:NUM_UNITS-1] unit_valid,
    input  gpr_result_t          unit_result [0:NUM_UNITS-1],
    output logic [0:NUM_UNITS-1] unit_ready,

    // SPR result source
    input  logic                 spr_valid,
    input  spr_write_t           spr_in,
    output logic                 spr_ready,

    // Register file write ports
    output gpr_write_t           gpr_wr,
    output spr_write_t           spr_wr,
    output cr0_write_t           cr0_wr
);

    logic [0:UNIT_IDX_WIDTH-1] ptr;
    logic [0:UNIT_IDX_WIDTH-1] first_idx;
    logic                      first_found;
    logic [0:UNIT_IDX_WIDTH-1] noxer_idx;
    logic                      noxer_found;
    grant_t                    grant;

    rr_pointer u_rr_pointer (
        .clk   (clk),
        .rst   (rst),
        .grant (grant),
        .ptr   (ptr)
    );

    unit_search u_unit_search (
        .ptr         (ptr),
        .unit_valid  (unit_valid),
        .unit_result (unit_result),
        .first_idx   (first_idx),
        .first_found (first_found),
        .noxer_idx   (noxer_idx),
        .noxer_found (noxer_found)
    );

    spr_turn_fsm u_spr_turn_fsm (
        .clk         (clk),
        .rst         (rst),
        .spr_valid   (spr_valid),
        .first_idx   (first_idx),
        .first_found (first_found),
        .noxer_idx   (noxer_idx),
        .noxer_found (noxer_found),
        .grant       (grant),
        .unit_ready  (unit_ready),
        .spr_ready   (spr_ready)
    );

    wb_output_stage u_wb_output_stage (
        .clk         (clk),
        .rst         (rst),
        .grant       (grant),
        .unit_result (unit_result),
        .spr_in      (spr_in),
        .gpr_wr      (gpr_wr),
        .spr_wr      (spr_wr),
        .cr0_wr      (cr0_wr)
    );

endmodule

//--- wb_checker.sv
// Write-back arbiter checker
// Models the round-robin pointer and SPR turn state from the observed inputs,
// checks the ready signals and compares the write ports one cycle later

`timescale 1ns/1ps

module wb_checker import wb_arbiter_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [0:NUM_UNITS-1] unit_valid,
    input  gpr_result_t          unit_result [0:NUM_UNITS-1],
    input  logic [0:NUM_UNITS-1] unit_ready,
    input  logic                 spr_valid,
    input  spr_write_t           spr_in,
    input  logic                 spr_ready,
    input  gpr_write_t           gpr_wr,
    input  spr_write_t           spr_wr,
    input  cr0_write_t           cr0_wr,
    input  logic                 table_check_en,
    input  logic [0:NUM_UNITS-1] exp_unit_ready,
    input  logic                 exp_spr_ready,
    output int                   error_count
);

    int                   errors = 0;
    logic                 primed = 1'b0;
    int                   ptr_model;
    turn_state_t          turn_model;
    gpr_write_t           exp_gpr;
    spr_write_t           exp_spr;
    cr0_write_t           exp_cr0;
    logic [0:NUM_UNITS-1] noxer;
    logic [0:NUM_UNITS-1] ready_model;
    int                   first_unit;
    int                   noxer_unit;
    int                   grant_unit;
    logic                 grant_spr;
    gpr_result_t          sel;

    assign error_count = errors;

    // Index of the first set request at or after start, -1 if none
    function automatic int first_from(input logic [0:NUM_UNITS-1] req, input int start);
        int idx;
        for (int k = 0; k < NUM_UNITS; k++) begin
            idx = (start + k) % NUM_UNITS;
            if (req[idx]) begin
                return idx;
            end
        end
        return -1;
    endfunction

    task automatic check_value(
        input string       name,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        if (actual !== expected) begin
            errors++;
            $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_ports();
        check_value("gpr_wr.valid", 32'(exp_gpr.valid), 32'(gpr_wr.valid));
        if (exp_gpr.valid) begin
            check_value("gpr_wr.tag", 32'(exp_gpr.tag), 32'(gpr_wr.tag));
            check_value("gpr_wr.reg_addr", 32'(exp_gpr.reg_addr), 32'(gpr_wr.reg_addr));
            check_value("gpr_wr.data", exp_gpr.data, gpr_wr.data);
        end
        check_value("spr_wr.valid", 32'(exp_spr.valid), 32'(spr_wr.valid));
        if (exp_spr.valid) begin
            check_value("spr_wr.tag", 32'(exp_spr.tag), 32'(spr_wr.tag));
            check_value("spr_wr.spr_addr", 32'(exp_spr.spr_addr), 32'(spr_wr.spr_addr));
            check_value("spr_wr.data", exp_spr.data, spr_wr.data);
        end
        check_value("cr0_wr.valid", 32'(exp_cr0.valid), 32'(cr0_wr.valid));
        if (exp_cr0.valid) begin
            check_value("cr0_wr.tag", 32'(exp_cr0.tag), 32'(cr0_wr.tag));
            check_value("cr0_wr.field", 32'(exp_cr0.field), 32'(cr0_wr.field));
        end
    endtask

    always @(posedge clk) begin
        // Outputs now show what was transferred at the previous edge
        if (primed) begin
            check_ports();
        end

        if (rst) begin
            ptr_model  = 0;
            turn_model = turn_gpr;
            exp_gpr    = '0;
            exp_spr    = '0;
            exp_cr0    = '0;
            primed     = 1'b1;
        end else begin
            for (int i = 0; i < NUM_UNITS; i++) begin
                noxer[i] = unit_valid[i] && !unit_result[i].cond.xer_valid;
            end
            first_unit = first_from(unit_valid, ptr_model);
            noxer_unit = first_from(noxer, ptr_model);
            grant_unit = -1;
            grant_spr  = 1'b0;

            if (!spr_valid) begin
                grant_unit = first_unit;
            end else if (turn_model == turn_spr) begin
                grant_spr  = 1'b1;
                grant_unit = noxer_unit;
                turn_model = turn_gpr;
            end else begin
                if (noxer_unit >= 0) begin
                    grant_spr  = 1'b1;
                    grant_unit = noxer_unit;
                end else if (first_unit >= 0) begin
                    grant_unit = first_unit;
                end else begin
                    grant_spr = 1'b1;
                end
                turn_model = turn_spr;
            end

            ready_model = '0;
            if (grant_unit >= 0) begin
                ready_model[grant_unit] = 1'b1;
            end
            check_value("unit_ready", 32'(ready_model), 32'(unit_ready));
            check_value("spr_ready", 32'(grant_spr), 32'(spr_ready));
            if (table_check_en) begin
                check_value("unit_ready (table)", 32'(exp_unit_ready), 32'(unit_ready));
                check_value("spr_ready (table)", 32'(exp_spr_ready), 32'(spr_ready));
            end

            exp_gpr = '0;
            exp_spr = '0;
            exp_cr0 = '0;
            if (grant_unit >= 0) begin
                sel              = unit_result[grant_unit];
                exp_gpr.valid    = 1'b1;
                exp_gpr.tag      = sel.tag;
                exp_gpr.reg_addr = sel.reg_addr;
                exp_gpr.data     = sel.data;
                if (sel.cond.cr0_valid) begin
                    // Bit 0 is the sign bit in this numbering
                    exp_cr0.valid = 1'b1;
                    exp_cr0.tag   = sel.tag;
                    exp_cr0.field = {sel.data[0], !sel.data[0] && (sel.data != 0),
                                     sel.data == 0, sel.cond.so};
                end
                if (sel.cond.xer_valid) begin
                    exp_spr.valid    = 1'b1;
                    exp_spr.tag      = sel.tag;
                    exp_spr.spr_addr = XER_SPR_ADDR;
                    exp_spr.data     = sel.cond.xer;
                end
                ptr_model = (grant_unit + 1) % NUM_UNITS;
            end
            if (grant_spr) begin
                exp_spr       = spr_in;
                exp_spr.valid = 1'b1;
            end
        end
    end

endmodule

//--- tb_write_back_arbiter.sv
// Write-back arbiter testbench
// Applies a per-cycle table of requests and expected readiness to the DUT

`timescale 1ns/1ps

module tb_write_back_arbiter import wb_arbiter_pkg::*; ();

    localparam int          RESET_CYCLES   = 5;
    localparam int          TIMEOUT_MARGIN = 20;
    localparam logic [31:0] SEED           = 32'h25bb;

    // Data modes for fresh unit results
    localparam logic [1:0] NEG  = 2'd0;
    localparam logic [1:0] POS  = 2'd1;
    localparam logic [1:0] ZERO = 2'd2;
    localparam logic [1:0] RND  = 2'd3;

    // Unit bit masks read left to right as unit 0 to unit 7
    typedef struct packed {
        logic [0:NUM_UNITS-1] valid;
        logic [0:NUM_UNITS-1] xer_valid;
        logic [0:NUM_UNITS-1] cr0_valid;
        logic [0:NUM_UNITS-1] so;
        logic                 spr_valid;
        logic [1:0]           mode;
        logic [0:NUM_UNITS-1] exp_ready;
        logic                 exp_spr_ready;
    } row_t;

    logic                 clk;
    logic                 rst;
    logic [0:NUM_UNITS-1] unit_valid;
    gpr_result_t          unit_result [0:NUM_UNITS-1];
    logic [0:NUM_UNITS-1] unit_ready;
    logic                 spr_valid;
    spr_write_t           spr_in;
    logic                 spr_ready;
    gpr_write_t           gpr_wr;
    spr_write_t           spr_wr;
    cr0_write_t           cr0_wr;
    logic                 table_check_en;
    logic [0:NUM_UNITS-1] exp_unit_ready;
    logic                 exp_spr_ready;
    int                   error_count;
    int                   cycle_count;
    int                   cycle_limit;
    row_t                 rows [$];

    write_back_arbiter uut (
        .clk         (clk),
        .rst         (rst),
        .unit_valid  (unit_valid),
        .unit_result (unit_result),
        .unit_ready  (unit_ready),
        .spr_valid   (spr_valid),
        .spr_in      (spr_in),
        .spr_ready   (spr_ready),
        .gpr_wr      (gpr_wr),
        .spr_wr      (spr_wr),
        .cr0_wr      (cr0_wr)
    );

    wb_checker chk (
        .clk            (clk),
        .rst            (rst),
        .unit_valid     (unit_valid),
        .unit_result    (unit_result),
        .unit_ready     (unit_ready),
        .spr_valid      (spr_valid),
        .spr_in         (spr_in),
        .spr_ready      (spr_ready),
        .gpr_wr         (gpr_wr),
        .spr_wr         (spr_wr),
        .cr0_wr         (cr0_wr),
        .table_check_en (table_check_en),
        .exp_unit_ready (exp_unit_ready),
        .exp_spr_ready  (exp_spr_ready),
        .error_count    (error_count)
    );

    always #5 clk = ~clk;

    task automatic add_row(
        input logic [0:NUM_UNITS-1] v,
        input logic [0:NUM_UNITS-1] xv,
        input logic [0:NUM_UNITS-1] cv,
        input logic [0:NUM_UNITS-1] so_bits,
        input logic                 sv,
        input logic [1:0]           mode,
        input logic [0:NUM_UNITS-1] er,
        input logic                 esr
    );
        row_t row;
        row = {v, xv, cv, so_bits, sv, mode, er, esr};
        rows.push_back(row);
    endtask

    task automatic load_table();
        // Round robin with every unit requesting, then wrap back to unit 0
        add_row(8'b11111111, 8'b00000000, 8'b00000000, 8'b00000000, 0, RND, 8'b10000000, 0);
        add_row(8'b11111111, 8'b00000000, 8'b00000000, 8'b00000000, 0, RND, 8'b01000000, 0);
        add_row(8'b11111111, 8'b00000000, 8'b00000000, 8'b00000000, 0, RND, 8'b00100000, 0);
        add_row(8'b11111111, 8'b00000000, 8'b00000000, 8'b00000000, 0, RND, 8'b00010000, 0);
        add_row(8'b11111111, 8'b00000000, 8'b00000000, 8'b00000000, 0, RND, 8'b00001000, 0);
        add_row(8'b11111111, 8'b00000000, 8'b00000000, 8'b00000000, 0, RND, 8'b00000100, 0);
        add_row(8'b11111111, 8'b00000000, 8'b00000000, 8'b00000000, 0, RND, 8'b00000010, 0);
        add_row(8'b11111111, 8'b00000000, 8'b00000000, 8'b00000000, 0, RND, 8'b00000001, 0);
        add_row(8'b11111111, 8'b00000000, 8'b00000000, 8'b00000000, 0, RND, 8'b10000000, 0);
        // Held units drain in pointer order
        add_row(8'b00000000, 8'b00000000, 8'b00000000, 8'b00000000, 0, RND, 8'b01000000, 0);
        add_row(8'b00000000, 8'b00000000, 8'b00000000, 8'b00000000, 0, RND, 8'b00100000, 0);
        add_row(8'b00000000, 8'b00000000, 8'b00000000, 8'b00000000, 0, RND, 8'b00010000, 0);
        add_row(8'b00000000, 8'b00000000, 8'b00000000, 8'b00000000, 0, RND, 8'b00001000, 0);
        add_row(8'b00000000, 8'b00000000, 8'b00000000, 8'b00000000, 0, RND, 8'b00000100, 0);
        add_row(8'b00000000, 8'b00000000, 8'b00000000, 8'b00000000, 0, RND, 8'b00000010, 0);
        add_row(8'b00000000, 8'b00000000, 8'b00000000, 8'b00000000, 0, RND, 8'b00000001, 0);
        // CR0 from negative, positive and zero results
        add_row(8'b01000000, 8'b00000000, 8'b01000000, 8'b01000000, 0, NEG, 8'b01000000, 0);
        add_row(8'b00100000, 8'b00000000, 8'b00100000, 8'b00000000, 0, POS, 8'b00100000, 0);
        add_row(8'b00010000, 8'b00000000, 8'b00010000, 8'b00010000, 0, ZERO, 8'b00010000, 0);
        add_row(8'b00001000, 8'b00000000, 8'b00001000, 8'b00000000, 0, NEG, 8'b00001000, 0);
        add_row(8'b00000100, 8'b00000000, 8'b00000100, 8'b00000100, 0, POS, 8'b00000100, 0);
        add_row(8'b00000010, 8'b00000000, 8'b00000010, 8'b00000000, 0, ZERO, 8'b00000010, 0);
        add_row(8'b00000001, 8'b00000000, 8'b00000000, 8'b00000001, 0, NEG, 8'b00000001, 0);
        // XER updates with a free SPR port
        add_row(8'b10000000, 8'b10000000, 8'b10000000, 8'b10000000, 0, RND, 8'b10000000, 0);
        add_row(8'b00010000, 8'b00010000, 8'b00000000, 8'b00000000, 0, POS, 8'b00010000, 0);
        // SPR alone, then paired with units that leave XER alone
        add_row(8'b00000000, 8'b00000000, 8'b00000000, 8'b00000000, 1, RND, 8'b00000000, 1);
        add_row(8'b00000100, 8'b00000000, 8'b00000100, 8'b00000000, 1, RND, 8'b00000100, 1);
        add_row(8'b00000010, 8'b00000000, 8'b00000000, 8'b00000000, 1, RND, 8'b00000010, 1);
        add_row(8'b00000000, 8'b00000000, 8'b00000000, 8'b00000000, 0, RND, 8'b00000000, 0);
        // SPR against XER writers takes turns with them
        add_row(8'b11000000, 8'b11000000, 8'b00000000, 8'b00000000, 1, RND, 8'b00000000, 1);
        add_row(8'b11000000, 8'b11000000, 8'b00000000, 8'b00000000, 1, RND, 8'b10000000, 0);
        add_row(8'b01000000, 8'b01000000, 8'b00000000, 8'b00000000, 1, RND, 8'b00000000, 1);
        add_row(8'b01000000, 8'b01000000, 8'b00000000, 8'b00000000, 1, RND, 8'b01000000, 0);
        add_row(8'b00000000, 8'b00000000, 8'b00000000, 8'b00000000, 1, RND, 8'b00000000, 1);
        // Held requests resume from the pointer
        add_row(8'b10101010, 8'b00000000, 8'b10101010, 8'b10001000, 0, RND, 8'b00100000, 0);
        add_row(8'b10011010, 8'b00000000, 8'b00010000, 8'b00000000, 0, NEG, 8'b00010000, 0);
        add_row(8'b10001010, 8'b00000000, 8'b00000000, 8'b00000000, 0, RND, 8'b00001000, 0);
        add_row(8'b10000010, 8'b00000000, 8'b00000000, 8'b00000000, 1, RND, 8'b00000010, 1);
        add_row(8'b10000000, 8'b00000000, 8'b00000000, 8'b00000000, 0, RND, 8'b10000000, 0);
        add_row(8'b00000000, 8'b00000000, 8'b00000000, 8'b00000000, 0, RND, 8'b00000000, 0);
        add_row(8'b00000000, 8'b00000000, 8'b00000000, 8'b00000000, 0, RND, 8'b00000000, 0);
    endtask

    function automatic logic [31:0] data_for_mode(input logic [1:0] mode);
        logic [31:0] r;
        r = $urandom;
        case (mode)
            NEG:     return r | 32'h8000_0000;
            POS:     return (r & 32'h7fff_ffff) | 32'h1;
            ZERO:    return '0;
            default: return r;
        endcase
    endfunction

    // Sources that were not granted at this edge keep their request unchanged
    task automatic apply_row(input row_t row);
        logic [0:NUM_UNITS-1] held;
        logic                 spr_held;
        gpr_result_t          res;
        spr_write_t           s;
        held     = unit_valid & ~unit_ready;
        spr_held = spr_valid & ~spr_ready;
        for (int i = 0; i < NUM_UNITS; i++) begin
            res.tag            = TAG_WIDTH'($urandom);
            res.reg_addr       = GPR_ADDR_WIDTH'($urandom);
            res.data           = data_for_mode(row.mode);
            res.cond.xer_valid = row.xer_valid[i];
            res.cond.xer       = $urandom;
            res.cond.cr0_valid = row.cr0_valid[i];
            res.cond.so        = row.so[i];
            if (!held[i]) begin
                unit_valid[i]  <= row.valid[i];
                unit_result[i] <= res;
            end
        end
        s.valid    = 1'b0;
        s.tag      = TAG_WIDTH'($urandom);
        s.spr_addr = SPR_ADDR_WIDTH'($urandom);
        s.data     = $urandom;
        if (!spr_held) begin
            spr_valid <= row.spr_valid;
            spr_in    <= s;
        end
        exp_unit_ready <= row.exp_ready;
        exp_spr_ready  <= row.exp_spr_ready;
        table_check_en <= 1'b1;
    endtask

    initial begin
        void'($urandom(SEED));
        clk            = 1'b0;
        rst            = 1'b1;
        unit_valid     = '0;
        spr_valid      = 1'b0;
        spr_in         = '0;
        table_check_en = 1'b0;
        exp_unit_ready = '0;
        exp_spr_ready  = 1'b0;
        cycle_count    = 0;
        for (int i = 0; i < NUM_UNITS; i++) begin
            unit_result[i] = '0;
        end
        load_table();
        cycle_limit = rows.size() + TIMEOUT_MARGIN;

        fork
            begin
                while (cycle_count < cycle_limit) begin
                    @(posedge clk);
                    cycle_count++;
                end
                $display("Timeout: run did not finish within %0d cycles", cycle_limit);
                $display("Checks failed");
                $finish;
            end
        join_none

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        for (int r = 0; r < rows.size(); r++) begin
            apply_row(rows[r]);
            @(posedge clk);
        end
        unit_valid     <= '0;
        spr_valid      <= 1'b0;
        table_check_en <= 1'b0;
        repeat (2) @(posedge clk);
        // Let the last compare at the rising edge settle
        @(negedge clk);

        $display("Error count: %0d", error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
wb_arbiter_pkg.sv
rr_pointer.sv
unit_search.sv
spr_turn_fsm.sv
wb_output_stage.sv
write_back_arbiter.sv
wb_checker.sv
tb_write_back_arbiter.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the write-back arbiter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module tb_write_back_arbiter -o tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/tb_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "All checks passed"; then
    exit 0
fi
echo "Simulation did not report a pass"
exit 1
